// ==== Makefile ====
# Verilator build, run and lint for the tag register file

TOP := tb_tag_regfile

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f design/*.sv testbench/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
		--top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f flist.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== design/entry_array.sv ====
// Storage for the register file: one flop word per entry.
// An entry loads its merged write word at the rising edge of gramclk when
// its select bit is set; synchronous reset clears every entry to zero.

`default_nettype none

module entry_array
    import regfile_pkg::*;
(
    input  logic       gramclk,
    input  logic       rst_n,
    input  entry_sel_t wr_sel,
    input  entry_u     wr_word [ENTRIES-1:0],
    output entry_u     entries [ENTRIES-1:0]
);

    // ==============================
    // Entry registers
    // ==============================
    always_ff @(posedge gramclk) begin
        if (!rst_n) begin
            for (int e = 0; e < ENTRIES; e++) begin
                entries[e] <= '0;
            end
        end else begin
            for (int e = 0; e < ENTRIES; e++) begin
                if (wr_sel[e]) begin
                    entries[e] <= wr_word[e];
                end
            end
        end
    end

    // An X on a select would silently corrupt or skip an entry
    a_wr_sel_known: assert property (@(posedge gramclk) disable iff (!rst_n)
        !$isunknown(wr_sel))
        else $error("write select has unknown bits");

endmodule

`default_nettype wire

// ==== design/read_mux.sv ====
// Binary-address read multiplexers, one per read port.
// Each port picks its addressed entry combinationally; ports are
// independent and may all address the same entry.

`default_nettype none

module read_mux
    import regfile_pkg::*;
#(
    parameter int num_rd_ports = 2
) (
    input  addr_t  rd_addr [num_rd_ports-1:0],
    input  entry_u entries [ENTRIES-1:0],
    output entry_u rd_data [num_rd_ports-1:0]
);

    // ==============================
    // Per-port mux
    // ==============================
    always_comb begin
        for (int p = 0; p < num_rd_ports; p++) begin
            // Raw view with no field decode on the read side
            rd_data[p].raw = entries[rd_addr[p]].raw;
        end
    end

endmodule

`default_nettype wire

// ==== design/regfile_pkg.sv ====
// Shared types and geometry for the tag register file.
// Every RTL module of the register file imports this package with a wildcard
// import in its module header.

`default_nettype none

package regfile_pkg;

    // ==============================
    // Entry geometry
    // ==============================
    localparam int ENTRIES   = 16;
    localparam int ADDR_W    = $clog2(ENTRIES);
    localparam int DATA_W    = 32;
    // Tag field sits at the top of the word in bits 31:20
    localparam int TAG_W     = 12;
    localparam int PAYLOAD_W = DATA_W - TAG_W;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [ENTRIES-1:0] entry_sel_t;

    // ==============================
    // Entry word
    // ==============================
    typedef struct packed {
        tag_t                 tag;
        logic [PAYLOAD_W-1:0] payload;
    } entry_fields_t;

    // Read and write paths see a raw word, the CAM sees tag plus payload
    typedef union packed {
        logic [DATA_W-1:0] raw;
        entry_fields_t     fields;
    } entry_u;

    // One write port request
    typedef struct packed {
        logic   en;
        addr_t  addr;
        entry_u data;
    } wr_req_t;

endpackage

`default_nettype wire

// ==== design/tag_cam.sv ====
// Tag match across all entries.
// Compares cam_tag with the tag field, bits 31:20, of every stored entry
// and returns one hit bit per entry; several bits may be set at once.

`default_nettype none

module tag_cam
    import regfile_pkg::*;
(
    input  tag_t       cam_tag,
    input  entry_u     entries [ENTRIES-1:0],
    output entry_sel_t cam_hit
);

    // ==============================
    // Compare
    // ==============================
    always_comb begin
        for (int e = 0; e < ENTRIES; e++) begin
            // Field view of the same stored word
            cam_hit[e] = (entries[e].fields.tag == cam_tag);
        end
    end

endmodule

`default_nettype wire

// ==== design/tag_regfile.sv ====
// Flop-based tag register file, 16 entries of 32 bits.
// Writes land at the next rising edge of gramclk; reads and the tag CAM
// look at stored contents combinationally.
// The caller must not enable two write ports on one address in a cycle.

`default_nettype none

module tag_regfile
    import regfile_pkg::*;
#(
    parameter int num_wr_ports = 2,
    parameter int num_rd_ports = 2
) (
    input  logic       gramclk,
    input  logic       rst_n,

    // Write ports
    input  wr_req_t    wr_req  [num_wr_ports-1:0],

    // Read ports
    input  addr_t      rd_addr [num_rd_ports-1:0],
    output entry_u     rd_data [num_rd_ports-1:0],

    // Tag match
    input  tag_t       cam_tag,
    output entry_sel_t cam_hit
);

    // ==============================
    // Internal nets
    // ==============================
    entry_sel_t wr_sel;
    entry_u     wr_word [ENTRIES-1:0];
    entry_u     entries [ENTRIES-1:0];

    // Write select decode and data merge across ports
    write_port_merge #(
        .num_wr_ports (num_wr_ports)
    ) u_write_port_merge (
        .gramclk (gramclk),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .wr_sel  (wr_sel),
        .wr_word (wr_word)
    );

    // Storage
    entry_array u_entry_array (
        .gramclk (gramclk),
        .rst_n   (rst_n),
        .wr_sel  (wr_sel),
        .wr_word (wr_word),
        .entries (entries)
    );

    // ==============================
    // Lookup side
    // ==============================
    read_mux #(
        .num_rd_ports (num_rd_ports)
    ) u_read_mux (
        .rd_addr (rd_addr),
        .entries (entries),
        .rd_data (rd_data)
    );

    tag_cam u_tag_cam (
        .cam_tag (cam_tag),
        .entries (entries),
        .cam_hit (cam_hit)
    );

endmodule

`default_nettype wire

// ==== design/write_port_merge.sv ====
// Turns the write port requests into per-entry write enables and data.
// Each port's binary address becomes a one-hot row gated by its enable;
// the rows are transposed into per-entry columns, OR-ed into wr_sel, and
// used to AND-OR select the data landing in each entry.
// Purely combinational apart from the port conflict check.

`default_nettype none

module write_port_merge
    import regfile_pkg::*;
#(
    parameter int num_wr_ports = 2
) (
    input  logic       gramclk,
    input  logic       rst_n,
    input  wr_req_t    wr_req  [num_wr_ports-1:0],
    output entry_sel_t wr_sel,
    output entry_u     wr_word [ENTRIES-1:0]
);

    entry_sel_t              wr_row [num_wr_ports-1:0];
    logic [num_wr_ports-1:0] wr_col [ENTRIES-1:0];

    // ==============================
    // Address decode
    // ==============================
    always_comb begin
        for (int p = 0; p < num_wr_ports; p++) begin
            wr_row[p] = {ENTRIES{wr_req[p].en}} & (entry_sel_t'(1) << wr_req[p].addr);
        end
    end

    // Rows per port become columns per entry
    always_comb begin
        for (int e = 0; e < ENTRIES; e++) begin
            for (int p = 0; p < num_wr_ports; p++) begin
                wr_col[e][p] = wr_row[p][e];
            end
            wr_sel[e] = |wr_col[e];
        end
    end

    // ==============================
    // Data merge
    // ==============================
    // At most one column bit is set per entry, so the OR picks one port
    always_comb begin
        for (int e = 0; e < ENTRIES; e++) begin
            wr_word[e].raw = '0;
            for (int p = 0; p < num_wr_ports; p++) begin
                wr_word[e].raw |= wr_req[p].data.raw & {DATA_W{wr_col[e][p]}};
            end
        end
    end

    // ==============================
    // Port conflict check
    // ==============================
    logic [num_wr_ports-1:0][num_wr_ports-1:0] addr_match;
    logic                                      wr_conflict;

    always_comb begin
        addr_match = '0;
        for (int i = 0; i < num_wr_ports; i++) begin
            for (int j = i + 1; j < num_wr_ports; j++) begin
                addr_match[i][j] = wr_req[i].en & wr_req[j].en &
                                   (wr_req[i].addr == wr_req[j].addr);
            end
        end
        wr_conflict = |addr_match;
    end

    // A merged word from two ports would corrupt the entry
    a_no_wr_conflict: assert property (@(posedge gramclk) disable iff (!rst_n)
        !wr_conflict)
        else $error("two enabled write ports target the same entry");

endmodule

`default_nettype wire

// ==== flist.f ====
design/regfile_pkg.sv
design/write_port_merge.sv
design/entry_array.sv
design/read_mux.sv
design/tag_cam.sv
design/tag_regfile.sv
testbench/tb_clock_gen.sv
testbench/tb_tag_regfile.sv

// ==== testbench/tb_clock_gen.sv ====
// Clock and reset source for the register file testbench.
// Toggles gramclk every half period and holds rst_n low for a number of
// rising edges, releasing it shortly after the last one.

`default_nettype none

module tb_clock_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 8
) (
    output logic gramclk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        gramclk = 1'b0;
        forever #half_period gramclk = ~gramclk;
    end

    // Release lands between edges like every other driven input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge gramclk);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_tag_regfile.sv ====
// Directed testbench for the tag register file.
// Drives the write, read and tag-match ports of the DUT, keeps a reference
// copy of the 16 entries and compares read data and hit vectors with it.
// Inputs change 2 ns after a rising edge, outputs are sampled before the next.

`default_nettype none

module tb_tag_regfile
    import regfile_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_cycles   = 400;
    localparam int drive_delay  = 2;
    localparam int sample_delay = 15;

    logic       gramclk;
    logic       rst_n;
    wr_req_t    wr_req  [1:0];
    addr_t      rd_addr [1:0];
    entry_u     rd_data [1:0];
    tag_t       cam_tag;
    entry_sel_t cam_hit;

    // Reference copy of the stored entries
    logic [DATA_W-1:0] model [ENTRIES];
    logic [31:0]       lfsr_state;
    int                error_count;
    int                tests_passed;
    int                tests_failed;
    int                cycle_count;

    tb_clock_gen #(
        .half_period  (10),
        .reset_cycles (8)
    ) u_clock_gen (
        .gramclk (gramclk),
        .rst_n   (rst_n)
    );

    tag_regfile #(
        .num_wr_ports (2),
        .num_rd_ports (2)
    ) dut0 (
        .gramclk (gramclk),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .cam_tag (cam_tag),
        .cam_hit (cam_hit)
    );

    // ==============================
    // Stimulus helpers
    // ==============================
    // Galois LFSR with taps 32 22 2 1
    function automatic logic lfsr_step_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsr_step_bit()};
        end
        return value;
    endfunction

    // One hit bit per entry whose top 12 bits equal the tag
    function automatic entry_sel_t expected_hits(input tag_t tag);
        entry_sel_t hits;
        for (int e = 0; e < ENTRIES; e++) begin
            hits[e] = (model[e][31:20] == tag);
        end
        return hits;
    endfunction

    // Wait for the edge, commit the writes presented there, then move to drive time
    task automatic next_cycle();
        @(posedge gramclk);
        for (int p = 0; p < 2; p++) begin
            if (wr_req[p].en) begin
                model[wr_req[p].addr] = wr_req[p].data.raw;
            end
        end
        #drive_delay;
    endtask

    task automatic sample_point();
        #sample_delay;
    endtask

    task automatic write_port(input int port, input addr_t addr, input logic [31:0] data);
        wr_req[port].en       = 1'b1;
        wr_req[port].addr     = addr;
        wr_req[port].data.raw = data;
    endtask

    task automatic clear_writes();
        wr_req[0] = '0;
        wr_req[1] = '0;
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %08h, actual %08h", test_name, expected,
                     actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string test_name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", test_name, error_count - errors_before);
        end
    endtask

    // Every address on both read ports with port 1 walking downwards
    task automatic check_all_entries(input string test_name);
        for (int a = 0; a < ENTRIES; a++) begin
            rd_addr[0] = addr_t'(a);
            rd_addr[1] = addr_t'(ENTRIES - 1 - a);
            sample_point();
            check_value(test_name, model[a], rd_data[0].raw);
            check_value(test_name, model[ENTRIES-1-a], rd_data[1].raw);
            next_cycle();
        end
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset_state();
        int errors_before;
        errors_before = error_count;
        check_all_entries("reset_state");
        cam_tag = '0;
        sample_point();
        check_value("reset_state", 32'h0000_ffff, 32'(cam_hit));
        next_cycle();
        cam_tag = 12'h5a5;
        sample_point();
        check_value("reset_state", 32'h0000_0000, 32'(cam_hit));
        next_cycle();
        report_test("reset_state", errors_before);
    endtask

    task automatic test_single_write();
        int          errors_before;
        addr_t       addr;
        logic [31:0] data;
        errors_before = error_count;
        repeat (3) begin
            addr = addr_t'(random_bits(ADDR_W));
            data = random_bits(DATA_W);
            write_port(0, addr, data);
            next_cycle();
            clear_writes();
            rd_addr[0] = addr;
            rd_addr[1] = addr;
            sample_point();
            check_value("single_write", data, rd_data[0].raw);
            check_value("single_write", data, rd_data[1].raw);
            next_cycle();
            check_all_entries("single_write");
        end
        report_test("single_write", errors_before);
    endtask

    task automatic test_dual_write();
        int          errors_before;
        addr_t       addr0;
        addr_t       addr1;
        logic [31:0] data0;
        logic [31:0] data1;
        errors_before = error_count;
        repeat (3) begin
            addr0 = addr_t'(random_bits(ADDR_W));
            // Offset of 1 to 8 keeps the two addresses apart
            addr1 = addr0 + addr_t'(1 + random_bits(3));
            data0 = random_bits(DATA_W);
            data1 = random_bits(DATA_W);
            write_port(0, addr0, data0);
            write_port(1, addr1, data1);
            next_cycle();
            clear_writes();
            rd_addr[0] = addr0;
            rd_addr[1] = addr1;
            sample_point();
            check_value("dual_write", data0, rd_data[0].raw);
            check_value("dual_write", data1, rd_data[1].raw);
            next_cycle();
            check_all_entries("dual_write");
        end
        report_test("dual_write", errors_before);
    endtask

    task automatic test_read_during_write();
        int          errors_before;
        logic [31:0] old_data;
        logic [31:0] data;
        logic [31:0] data_next;
        errors_before = error_count;
        old_data = model[9];
        data = random_bits(DATA_W);
        write_port(0, 4'h9, data);
        rd_addr[0] = 4'h9;
        rd_addr[1] = 4'h9;
        sample_point();
        check_value("read_during_write", old_data, rd_data[0].raw);
        check_value("read_during_write", old_data, rd_data[1].raw);
        next_cycle();
        clear_writes();
        sample_point();
        check_value("read_during_write", data, rd_data[0].raw);
        next_cycle();
        // Two overwrites in a row on the other port
        data = random_bits(DATA_W);
        data_next = random_bits(DATA_W);
        write_port(1, 4'h9, data);
        next_cycle();
        write_port(1, 4'h9, data_next);
        sample_point();
        check_value("read_during_write", data, rd_data[1].raw);
        next_cycle();
        clear_writes();
        sample_point();
        check_value("read_during_write", data_next, rd_data[0].raw);
        check_value("read_during_write", data_next, rd_data[1].raw);
        next_cycle();
        report_test("read_during_write", errors_before);
    endtask

    task automatic test_tag_match();
        int   errors_before;
        tag_t shared;
        errors_before = error_count;
        for (int k = 0; k < ENTRIES / 2; k++) begin
            write_port(0, addr_t'(2 * k), random_bits(DATA_W));
            write_port(1, addr_t'(2 * k + 1), random_bits(DATA_W));
            next_cycle();
        end
        shared = tag_t'(random_bits(TAG_W));
        write_port(0, 4'd2, {shared, model[2][PAYLOAD_W-1:0]});
        write_port(1, 4'd5, {shared, model[5][PAYLOAD_W-1:0]});
        next_cycle();
        write_port(0, 4'd11, {shared, model[11][PAYLOAD_W-1:0]});
        write_port(1, 4'd14, {shared, model[14][PAYLOAD_W-1:0]});
        next_cycle();
        clear_writes();
        cam_tag = shared;
        sample_point();
        check_value("tag_match", 32'(expected_hits(shared)), 32'(cam_hit));
        next_cycle();
        // Search the tag of every entry in turn
        for (int e = 0; e < ENTRIES; e++) begin
            cam_tag = model[e][31:20];
            sample_point();
            check_value("tag_match", 32'(expected_hits(cam_tag)), 32'(cam_hit));
            next_cycle();
        end
        report_test("tag_match", errors_before);
    endtask

    // ==============================
    // Run
    // ==============================
    initial begin
        lfsr_state = 32'hd116;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int p = 0; p < 2; p++) begin
            wr_req[p] = '0;
            rd_addr[p] = '0;
        end
        cam_tag = '0;
        for (int e = 0; e < ENTRIES; e++) begin
            model[e] = '0;
        end
        wait (rst_n === 1'b1);
        next_cycle();
        test_reset_state();
        test_single_write();
        test_dual_write();
        test_read_during_write();
        test_tag_match();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge gramclk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
